/* test/spmv_stim.txt */
# commands, all numbers hex: X xi_addr xi_data | V kernel n val_word({col,value})
# S kernel_mask nnz0 nnz1 nnz2 nnz3 | E kernel result | B byte_addr | R kernel soft_rst
X 000000000000 00000003
X 000000000004 00000005
X ab0000000008 00000007
X 000010000000 00000002
X 000050000004 00000010
X 000020000000 ffffffff
X 00002000000c 00000004
X 000030000004 00000009
X 0000f0000008 00000006
V 0 0 0000000100000002
V 0 1 0000000000000004
V 0 2 000000020000000a
V 1 0 0000000100000003
V 1 1 0000000000000100
V 2 0 0000000000000002
V 2 1 0000000300000005
V 2 2 0000000000000001
V 3 0 0000000200000007
V 3 1 0000000100000001
B 30
B 100
# one kernel alone
S 1 3 0 0 0
E 0 5c
# all four kernels together
S f 2 2 3 2
E 0 16
E 1 230
E 2 11
E 3 33
# empty row
S 8 0 0 0 0
E 3 0
# soft reset held, start ignored, then released
R 1 1
S 2 0 2 0 0
R 1 0
S 2 0 2 0 0
E 1 230

/* all.f */
design/spmv_pkg.sv
design/spmv_config_regs.sv
design/xi_bank_array.sv
design/val_read_arbiter.sv
design/spmv_row_engine.sv
design/spmv_calc_top.sv
test/spmv_calc_tb.sv

/* Makefile */
TOP := spmv_calc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f all.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/spmv_calc_tb.sv */
// Testbench for spmv_calc_top: replays test/spmv_stim.txt against the DUT
// with a randomly stalling HBM Val model and checks results over AXI-lite.
`timescale 1ns/10ps
module spmv_calc_tb import spmv_pkg::*; ();

    logic       axis_clk = 1'b0;
    logic       arst_n;
    logic       axil_awvalid;
    axil_addr_t axil_awaddr;
    logic       axil_awready;
    logic       axil_wvalid;
    reg_word_t  axil_wdata;
    logic       axil_wready;
    logic       axil_bvalid;
    axi_resp_t  axil_bresp;
    logic       axil_bready;
    logic       axil_arvalid;
    axil_addr_t axil_araddr;
    logic       axil_arready;
    logic       axil_rvalid;
    reg_word_t  axil_rdata;
    axi_resp_t  axil_rresp;
    logic       axil_rready;
    logic       xi_wvalid;
    hbm_addr_t  xi_waddr;
    reg_word_t  xi_wdata;
    hbm_addr_t  hbm_araddr;
    logic       hbm_arvalid;
    logic       hbm_arready = 1'b0;
    val_word_t  hbm_rdata = '0;
    logic       hbm_rvalid = 1'b0;
    logic       hbm_rready;

    val_word_t   val_mem [hbm_addr_t];          // HBM Val contents by byte address
    reg_word_t   xi_ref [NUM_KERNEL][XI_DEPTH];
    reg_word_t   exp_result [NUM_KERNEL];
    reg_word_t   exp_count [NUM_KERNEL];
    logic        srst_held [NUM_KERNEL] = '{default: 1'b0};
    int          seed = 32'h84e4;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    logic        ar_will_fire = 1'b0;           // transfers decided at a falling edge
    logic        r_will_fire = 1'b0;
    logic        beat_pending = 1'b0;
    logic        rd_outstanding = 1'b0;         // read accepted, beat not yet taken
    int          beat_delay = 0;
    hbm_addr_t   ar_addr_q;

    spmv_calc_top dut0 (.*);

    always #4 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, a handshake or done bit never came",
                               cycle_count));
        end
    end

    // HBM Val model, one beat per read, random stalls on arready and rvalid
    always @(negedge axis_clk) begin
        if (!arst_n) begin
            hbm_arready    = 1'b0;
            hbm_rvalid     = 1'b0;
            beat_pending   = 1'b0;
            ar_will_fire   = 1'b0;
            r_will_fire    = 1'b0;
            rd_outstanding = 1'b0;
        end else begin
            if (r_will_fire) begin
                hbm_rvalid     = 1'b0;             // beat taken at the last rising edge
                rd_outstanding = 1'b0;
            end
            if (ar_will_fire) begin
                rd_outstanding = 1'b1;
                if (!val_mem.exists(ar_addr_q)) begin
                    fail_run($sformatf("HBM read at 0x%012h has no Val word loaded", ar_addr_q));
                end else begin
                    hbm_rdata    = val_mem[ar_addr_q];
                    beat_pending = 1'b1;
                    beat_delay   = $random(seed) & 3;
                end
            end
            if (beat_pending && !hbm_rvalid) begin
                if (beat_delay == 0) begin
                    hbm_rvalid   = 1'b1;
                    beat_pending = 1'b0;
                end else begin
                    beat_delay--;
                end
            end
            check_bit("hbm_rready", hbm_rready, rd_outstanding);
            hbm_arready  = hbm_arvalid && !beat_pending && (($random(seed) & 1) != 0);
            ar_will_fire = hbm_arvalid && hbm_arready;
            ar_addr_q    = hbm_araddr;
            r_will_fire  = hbm_rvalid && hbm_rready;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    // flags are {done, busy}
    task automatic check_flags(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    function automatic axil_addr_t reg_addr(input int k, input int j);
        return axil_addr_t'(12 * k + 4 * j);
    endfunction

    function automatic hbm_addr_t val_addr(input int k, input int n);
        return VAL_BASE_ADDR + hbm_addr_t'(k) * KERNEL_REGION + hbm_addr_t'(n) * 8;
    endfunction

    // sum of value * Xi[col] over the first nnz Val words of kernel k
    function automatic reg_word_t ref_dot(input int k, input reg_word_t nnz);
        reg_word_t acc;
        val_word_t w;
        acc = '0;
        for (int n = 0; n < int'(nnz); n++) begin
            w   = val_mem[val_addr(k, n)];
            acc = acc + w[31:0] * xi_ref[k][w[39:32]];   // wraps mod 2^32
        end
        return acc;
    endfunction

    task automatic lite_write(input axil_addr_t addr, input reg_word_t data,
                              output axi_resp_t resp);
        axil_awaddr  = addr;
        axil_wdata   = data;
        axil_awvalid = 1'b1;
        axil_wvalid  = 1'b1;
        do begin
            @(negedge axis_clk);
        end while (!axil_awready && !axil_wready); // accepted at the next rising edge
        check_bit("axil_awready", axil_awready, 1'b1);   // both readies rise together
        check_bit("axil_wready", axil_wready, 1'b1);
        @(negedge axis_clk);
        check_bit("axil_awready", axil_awready, 1'b0);
        check_bit("axil_wready", axil_wready, 1'b0);
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        axil_bready  = 1'b1;
        while (!axil_bvalid) @(negedge axis_clk);
        resp = axil_bresp;
        @(negedge axis_clk);
        axil_bready = 1'b0;
    endtask

    task automatic lite_read(input axil_addr_t addr, output reg_word_t data,
                             output axi_resp_t resp);
        axil_araddr  = addr;
        axil_arvalid = 1'b1;
        do begin
            @(negedge axis_clk);
        end while (!axil_arready);
        @(negedge axis_clk);
        axil_arvalid = 1'b0;
        axil_rready  = 1'b1;
        while (!axil_rvalid) @(negedge axis_clk);
        data = axil_rdata;
        resp = axil_rresp;
        @(negedge axis_clk);
        axil_rready = 1'b0;
    endtask

    task automatic write_reg(input axil_addr_t addr, input reg_word_t data);
        axi_resp_t resp;
        lite_write(addr, data, resp);
        check_resp("axil_bresp", resp, RESP_OKAY);
    endtask

    task automatic read_reg(input axil_addr_t addr, output reg_word_t data);
        axi_resp_t resp;
        lite_read(addr, data, resp);
        check_resp("axil_rresp", resp, RESP_OKAY);
    endtask

    task automatic xi_write(input hbm_addr_t addr, input reg_word_t data);
        hbm_addr_t masked;
        masked = addr & XI_ADDR_MASK;
        xi_ref[masked[29:28]][masked[9:2]] = data;   // kernel field, then entry
        xi_waddr  = addr;
        xi_wdata  = data;
        xi_wvalid = 1'b1;
        @(negedge axis_clk);
        xi_wvalid = 1'b0;
    endtask

    // fld[0] is the kernel mask, fld[k+1] the nnz of kernel k
    task automatic launch_kernels(input logic [63:0] fld [5]);
        reg_word_t nnz;
        reg_word_t rd;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (fld[0][k]) begin
                nnz = reg_word_t'(fld[k + 1]);
                write_reg(reg_addr(k, 1), nnz);
                exp_result[k] = srst_held[k] ? '0 : ref_dot(k, nnz);
                exp_count[k]  = srst_held[k] ? '0 : nnz;
            end
        end
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (fld[0][k]) begin
                write_reg(reg_addr(k, 0), {24'd0, srst_held[k], 7'd1});
            end
        end
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (fld[0][k] && srst_held[k]) begin
                read_reg(reg_addr(k, 0), rd);
                check_flags($sformatf("kernel%0d {done,busy}", k), rd[1:0], 2'b00);
            end else if (fld[0][k]) begin
                do begin
                    read_reg(reg_addr(k, 0), rd);  // poll the done bit
                end while (!rd[1]);
            end
        end
    endtask

    task automatic verify_kernel(input int k, input reg_word_t stim_val);
        reg_word_t rd;
        if (stim_val !== exp_result[k]) begin
            fail_run($sformatf("stim expects 0x%08h from kernel %0d, reference sum is 0x%08h",
                               stim_val, k, exp_result[k]));
        end
        read_reg(reg_addr(k, 0), rd);
        check_flags($sformatf("kernel%0d {done,busy}", k), rd[1:0], 2'b10);
        read_reg(reg_addr(k, 1), rd);
        check_word($sformatf("kernel%0d result", k), rd, exp_result[k]);
        write_reg(reg_addr(k, 2), 32'hffff_ffff);   // word 2 takes no data
        read_reg(reg_addr(k, 2), rd);
        check_word($sformatf("kernel%0d count", k), rd, exp_count[k]);
    endtask

    task automatic probe_bad_addr(input axil_addr_t addr);
        axi_resp_t resp;
        reg_word_t rd;
        lite_write(addr, 32'h0, resp);
        check_resp("axil_bresp", resp, RESP_SLVERR);
        lite_read(addr, rd, resp);
        check_resp("axil_rresp", resp, RESP_SLVERR);
    endtask

    task automatic hold_soft_reset(input int k, input logic on);
        reg_word_t rd;
        srst_held[k] = on;
        write_reg(reg_addr(k, 0), {24'd0, on, 7'd0});
        if (on) begin
            exp_result[k] = '0;
            exp_count[k]  = '0;
            read_reg(reg_addr(k, 0), rd);
            check_flags($sformatf("kernel%0d {done,busy}", k), rd[1:0], 2'b00);
            read_reg(reg_addr(k, 1), rd);
            check_word($sformatf("kernel%0d result", k), rd, 32'h0);
            read_reg(reg_addr(k, 2), rd);
            check_word($sformatf("kernel%0d count", k), rd, 32'h0);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          need;
        byte         cmd;
        string       line_buf;
        string       lines [$];
        logic [63:0] f [5];
        arst_n       = 1'b0;
        axil_awvalid = 1'b0;
        axil_awaddr  = '0;
        axil_wvalid  = 1'b0;
        axil_wdata   = '0;
        axil_bready  = 1'b0;
        axil_arvalid = 1'b0;
        axil_araddr  = '0;
        axil_rready  = 1'b0;
        xi_wvalid    = 1'b0;
        xi_waddr     = '0;
        xi_wdata     = '0;
        fd = $fopen("test/spmv_stim.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open test/spmv_stim.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line_buf, fd);
            if (code != 0) begin
                lines.push_back(line_buf);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * lines.size() + 200;
        repeat (2) @(negedge axis_clk);
        arst_n = 1'b1;
        @(negedge axis_clk);
        foreach (lines[i]) begin
            code = $sscanf(lines[i], " %c %h %h %h %h %h", cmd, f[0], f[1], f[2], f[3], f[4]);
            if (code < 1 || cmd == "#") begin
                continue;
            end
            need = (cmd == "S") ? 6 : (cmd == "V") ? 4 : (cmd == "B") ? 2 : 3;
            if (code < need) begin
                fail_run($sformatf("stim line %0d has too few fields", i + 1));
            end
            case (cmd)
                "X": xi_write(hbm_addr_t'(f[0]), reg_word_t'(f[1]));
                "V": val_mem[val_addr(int'(f[0]), int'(f[1]))] = f[2];
                "S": launch_kernels(f);
                "E": verify_kernel(int'(f[0]), reg_word_t'(f[1]));
                "B": probe_bad_addr(axil_addr_t'(f[0]));
                "R": hold_soft_reset(int'(f[0]), f[1][0]);
                default: fail_run($sformatf("unknown stim command %c on line %0d", cmd, i + 1));
            endcase
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* design/spmv_calc_top.sv */
// Top of the SpMV calc block: config registers, Xi banks, Val arbiter and
// NUM_KERNEL row engines, all on axis_clk.
`timescale 1ns/10ps
module spmv_calc_top import spmv_pkg::*; (
    input  logic       axis_clk,
    input  logic       arst_n,
    input  logic       axil_awvalid,
    input  axil_addr_t axil_awaddr,
    output logic       axil_awready,
    input  logic       axil_wvalid,
    input  reg_word_t  axil_wdata,
    output logic       axil_wready,
    output logic       axil_bvalid,
    output axi_resp_t  axil_bresp,
    input  logic       axil_bready,
    input  logic       axil_arvalid,
    input  axil_addr_t axil_araddr,
    output logic       axil_arready,
    output logic       axil_rvalid,
    output reg_word_t  axil_rdata,
    output axi_resp_t  axil_rresp,
    input  logic       axil_rready,
    input  logic       xi_wvalid,
    input  hbm_addr_t  xi_waddr,
    input  reg_word_t  xi_wdata,
    output hbm_addr_t  hbm_araddr,
    output logic       hbm_arvalid,
    input  logic       hbm_arready,
    input  val_word_t  hbm_rdata,
    input  logic       hbm_rvalid,
    output logic       hbm_rready
);
    kernel_cfg_t [NUM_KERNEL-1:0]    cfg;
    kernel_status_t [NUM_KERNEL-1:0] status;
    logic [NUM_KERNEL-1:0]           req_valid;
    hbm_addr_t [NUM_KERNEL-1:0]      req_addr;
    logic [NUM_KERNEL-1:0]           req_ready;
    logic [NUM_KERNEL-1:0]           rsp_valid;
    val_word_t                       rsp_data;   // shared, rsp_valid picks the owner
    xi_idx_t [NUM_KERNEL-1:0]        xi_idx;
    reg_word_t [NUM_KERNEL-1:0]      xi_data;

    spmv_config_regs u_config_regs (
        .axis_clk     (axis_clk),
        .arst_n       (arst_n),
        .axil_awvalid (axil_awvalid),
        .axil_awaddr  (axil_awaddr),
        .axil_awready (axil_awready),
        .axil_wvalid  (axil_wvalid),
        .axil_wdata   (axil_wdata),
        .axil_wready  (axil_wready),
        .axil_bvalid  (axil_bvalid),
        .axil_bresp   (axil_bresp),
        .axil_bready  (axil_bready),
        .axil_arvalid (axil_arvalid),
        .axil_araddr  (axil_araddr),
        .axil_arready (axil_arready),
        .axil_rvalid  (axil_rvalid),
        .axil_rdata   (axil_rdata),
        .axil_rresp   (axil_rresp),
        .axil_rready  (axil_rready),
        .cfg          (cfg),
        .status       (status)
    );

    xi_bank_array u_xi_banks (
        .axis_clk  (axis_clk),
        .arst_n    (arst_n),
        .xi_wvalid (xi_wvalid),
        .xi_waddr  (xi_waddr),
        .xi_wdata  (xi_wdata),
        .rd_idx    (xi_idx),
        .rd_data   (xi_data)
    );

    val_read_arbiter u_val_arbiter (
        .axis_clk    (axis_clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .hbm_araddr  (hbm_araddr),
        .hbm_arvalid (hbm_arvalid),
        .hbm_arready (hbm_arready),
        .hbm_rdata   (hbm_rdata),
        .hbm_rvalid  (hbm_rvalid),
        .hbm_rready  (hbm_rready)
    );

    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_engine
        spmv_row_engine #(
            .KERNEL_ID (k)
        ) u_row_engine (
            .axis_clk  (axis_clk),
            .arst_n    (arst_n),
            .cfg       (cfg[k]),
            .status    (status[k]),
            .req_valid (req_valid[k]),
            .req_addr  (req_addr[k]),
            .req_ready (req_ready[k]),
            .rsp_valid (rsp_valid[k]),
            .rsp_data  (rsp_data),
            .xi_idx    (xi_idx[k]),
            .xi_data   (xi_data[k])
        );
    end

endmodule

/* design/spmv_row_engine.sv */
// Row engine of one kernel: reads nnz Val words and accumulates value * Xi[col].
// Control bit 7 holds the engine cleared; a start with nnz 0 finishes at once.
`timescale 1ns/10ps
module spmv_row_engine import spmv_pkg::*; #(
    parameter int KERNEL_ID = 0
) (
    input  logic           axis_clk,
    input  logic           arst_n,
    input  kernel_cfg_t    cfg,
    output kernel_status_t status,
    output logic           req_valid,
    output hbm_addr_t      req_addr,
    input  logic           req_ready,
    input  logic           rsp_valid,
    input  val_word_t      rsp_data,
    output xi_idx_t        xi_idx,
    input  reg_word_t      xi_data
);
    engine_state_t state_q;
    reg_word_t     nnz_q;
    reg_word_t     val_q;
    reg_word_t     result_q;
    reg_word_t     count_q;        // also the index of the next Val word
    logic          start;
    logic          soft_rst;

    assign start    = cfg.ctrl[CTRL_START_BIT];
    assign soft_rst = cfg.ctrl[CTRL_SOFT_RST_BIT];

    assign req_valid = (state_q == FETCH);
    assign req_addr  = VAL_BASE_ADDR + hbm_addr_t'(KERNEL_ID) * KERNEL_REGION
                     + (hbm_addr_t'(count_q) << 3);

    // column index sits in the upper half of the beat, bank answers next cycle
    assign xi_idx = rsp_data[32 +: XI_IDX_W];

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= IDLE;
            nnz_q    <= '0;
            result_q <= '0;
            count_q  <= '0;
        end else if (soft_rst) begin
            state_q  <= IDLE;
            result_q <= '0;
            count_q  <= '0;
        end else begin
            case (state_q)
                IDLE, DONE: begin
                    if (start) begin
                        nnz_q    <= cfg.nnz;
                        result_q <= '0;
                        count_q  <= '0;
                        state_q  <= (cfg.nnz == '0) ? DONE : FETCH;
                    end
                end
                FETCH: begin
                    if (req_ready) begin
                        state_q <= WAIT_BEAT;
                    end
                end
                WAIT_BEAT: begin
                    if (rsp_valid) begin
                        state_q <= MAC;
                    end
                end
                MAC: begin
                    result_q <= result_q + val_q * xi_data;   // wraps mod 2^32
                    count_q  <= count_q + 32'd1;
                    state_q  <= (count_q + 32'd1 == nnz_q) ? DONE : FETCH;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state_q == WAIT_BEAT && rsp_valid) begin
            val_q <= rsp_data[31:0];
        end
    end

    always_comb begin
        status.busy   = (state_q == FETCH) || (state_q == WAIT_BEAT) || (state_q == MAC);
        status.done   = (state_q == DONE);
        status.result = result_q;
        status.count  = count_q;
    end

    a_no_req_idle: assert property (@(posedge axis_clk) disable iff (!arst_n)
        (state_q == IDLE || state_q == DONE) |-> !req_valid);

endmodule

/* design/val_read_arbiter.sv */
// Merges kernel Val reads onto the single HBM read port, round robin.
// One read in flight at a time; the beat goes back to the kernel that asked.
`timescale 1ns/10ps
module val_read_arbiter import spmv_pkg::*; (
    input  logic                          axis_clk,
    input  logic                          arst_n,
    input  logic [NUM_KERNEL-1:0]         req_valid,
    input  hbm_addr_t [NUM_KERNEL-1:0]    req_addr,
    output logic [NUM_KERNEL-1:0]         req_ready,
    output logic [NUM_KERNEL-1:0]         rsp_valid,
    output val_word_t                     rsp_data,
    output hbm_addr_t                     hbm_araddr,
    output logic                          hbm_arvalid,
    input  logic                          hbm_arready,
    input  val_word_t                     hbm_rdata,
    input  logic                          hbm_rvalid,
    output logic                          hbm_rready
);
    kernel_idx_t owner_q;          // holds the grant until its beat is back
    kernel_idx_t last_q;           // previous winner, search starts after it
    kernel_idx_t winner;
    logic        winner_found;
    logic        outstanding_q;
    logic        bus_free;

    assign bus_free = !hbm_arvalid && !outstanding_q;

    always_comb begin
        int unsigned idx;
        winner       = last_q;
        winner_found = 1'b0;
        for (int i = 1; i <= NUM_KERNEL; i++) begin
            idx = (int'(last_q) + i) % NUM_KERNEL;
            if (!winner_found && req_valid[idx]) begin
                winner       = kernel_idx_t'(idx);
                winner_found = 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            hbm_arvalid   <= 1'b0;
            outstanding_q <= 1'b0;
            owner_q       <= '0;
            last_q        <= kernel_idx_t'(NUM_KERNEL - 1);  // kernel 0 goes first
        end else begin
            if (bus_free && winner_found) begin
                hbm_arvalid <= 1'b1;
                owner_q     <= winner;
            end else if (hbm_arvalid && hbm_arready) begin
                hbm_arvalid   <= 1'b0;
                outstanding_q <= 1'b1;
            end else if (outstanding_q && hbm_rvalid) begin
                outstanding_q <= 1'b0;
                last_q        <= owner_q;
            end
        end
    end

    // the owner keeps its address steady until accepted
    assign hbm_araddr = req_addr[owner_q];
    assign hbm_rready = outstanding_q;
    assign rsp_data   = hbm_rdata;

    always_comb begin
        req_ready          = '0;
        rsp_valid          = '0;
        req_ready[owner_q] = hbm_arvalid && hbm_arready;
        rsp_valid[owner_q] = outstanding_q && hbm_rvalid;
    end

    a_rsp_onehot: assert property (@(posedge axis_clk) disable iff (!arst_n)
        $onehot0(rsp_valid));

endmodule

/* design/xi_bank_array.sv */
// Local Xi banks, one per kernel, filled from the Xi write strobe.
// Each kernel reads its own bank; data is valid one cycle after the index.
`timescale 1ns/10ps
module xi_bank_array import spmv_pkg::*; (
    input  logic                         axis_clk,
    input  logic                         arst_n,
    input  logic                         xi_wvalid,
    input  hbm_addr_t                    xi_waddr,
    input  reg_word_t                    xi_wdata,
    input  xi_idx_t [NUM_KERNEL-1:0]     rd_idx,
    output reg_word_t [NUM_KERNEL-1:0]   rd_data
);
    hbm_addr_t   masked_addr;
    kernel_idx_t wr_kernel;
    xi_idx_t     wr_idx;
    reg_word_t   bank [NUM_KERNEL][XI_DEPTH];

    assign masked_addr = xi_waddr & XI_ADDR_MASK;
    assign wr_kernel   = masked_addr[29:28];   // kernel region field
    assign wr_idx      = masked_addr[9:2];     // 32-bit entry within the bank

    always_ff @(posedge axis_clk) begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (xi_wvalid && wr_kernel == kernel_idx_t'(k)) begin
                bank[k][wr_idx] <= xi_wdata;
            end
            rd_data[k] <= bank[k][rd_idx[k]];
        end
    end

    // a write must land in an existing kernel bank
    a_xi_kernel_range: assert property (@(posedge axis_clk) disable iff (!arst_n)
        xi_wvalid |-> int'(wr_kernel) < NUM_KERNEL);

endmodule

/* design/spmv_config_regs.sv */
// AXI-lite slave holding ctrl/nnz per kernel and returning per-kernel status.
// Writes to ctrl with bit 0 set give the kernel a one-cycle start pulse.
`timescale 1ns/10ps
module spmv_config_regs import spmv_pkg::*; (
    input  logic                            axis_clk,
    input  logic                            arst_n,
    input  logic                            axil_awvalid,
    input  axil_addr_t                      axil_awaddr,
    output logic                            axil_awready,
    input  logic                            axil_wvalid,
    input  reg_word_t                       axil_wdata,
    output logic                            axil_wready,
    output logic                            axil_bvalid,
    output axi_resp_t                       axil_bresp,
    input  logic                            axil_bready,
    input  logic                            axil_arvalid,
    input  axil_addr_t                      axil_araddr,
    output logic                            axil_arready,
    output logic                            axil_rvalid,
    output reg_word_t                       axil_rdata,
    output axi_resp_t                       axil_rresp,
    input  logic                            axil_rready,
    output kernel_cfg_t [NUM_KERNEL-1:0]    cfg,
    input  kernel_status_t [NUM_KERNEL-1:0] status
);
    typedef struct packed {
        logic        hit;
        kernel_idx_t kern;
        logic [1:0]  word;
    } reg_sel_t;

    reg_sel_t  wr_sel;
    reg_sel_t  rd_sel;
    reg_word_t rd_word;
    logic      wr_fire;
    logic      rd_fire;

    // byte address to kernel and word, miss when beyond the map
    function automatic reg_sel_t decode(axil_addr_t addr);
        reg_sel_t sel;
        sel = '0;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            for (int j = 0; j < REG_WORDS; j++) begin
                if (addr[31:2] == 30'(k * REG_WORDS + j)) begin
                    sel.hit  = 1'b1;
                    sel.kern = kernel_idx_t'(k);
                    sel.word = 2'(j);
                end
            end
        end
        return sel;
    endfunction

    assign wr_sel  = decode(axil_awaddr);
    assign rd_sel  = decode(axil_araddr);
    assign wr_fire = axil_awready && axil_awvalid && axil_wvalid;
    assign rd_fire = axil_arready && axil_arvalid;

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            axil_awready <= 1'b0;
            axil_wready  <= 1'b0;
            axil_bvalid  <= 1'b0;
            axil_bresp   <= RESP_OKAY;
            cfg          <= '0;
        end else begin
            axil_awready <= axil_awvalid && axil_wvalid && !axil_bvalid && !axil_awready;
            axil_wready  <= axil_awvalid && axil_wvalid && !axil_bvalid && !axil_awready;
            for (int k = 0; k < NUM_KERNEL; k++) begin
                cfg[k].ctrl[CTRL_START_BIT] <= 1'b0;   // start lasts one cycle
            end
            if (wr_fire) begin
                axil_bvalid <= 1'b1;
                axil_bresp  <= wr_sel.hit ? RESP_OKAY : RESP_SLVERR;
                if (wr_sel.hit) begin
                    case (wr_sel.word)
                        2'd0:    cfg[wr_sel.kern].ctrl <= axil_wdata;
                        2'd1:    cfg[wr_sel.kern].nnz  <= axil_wdata;
                        default: ;                     // word 2 has nothing to store
                    endcase
                end
            end else if (axil_bready) begin
                axil_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (rd_sel.word)
            2'd0:    rd_word = {30'd0, status[rd_sel.kern].done, status[rd_sel.kern].busy};
            2'd1:    rd_word = status[rd_sel.kern].result;
            default: rd_word = status[rd_sel.kern].count;
        endcase
        if (!rd_sel.hit) begin
            rd_word = '0;
        end
    end

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            axil_arready <= 1'b0;
            axil_rvalid  <= 1'b0;
            axil_rresp   <= RESP_OKAY;
        end else begin
            axil_arready <= axil_arvalid && !axil_rvalid && !axil_arready;
            if (rd_fire) begin
                axil_rvalid <= 1'b1;
                axil_rresp  <= rd_sel.hit ? RESP_OKAY : RESP_SLVERR;
            end else if (axil_rready) begin
                axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            axil_rdata <= rd_word;                     // held while rvalid waits
        end
    end

    a_bvalid_hold: assert property (@(posedge axis_clk) disable iff (!arst_n)
        axil_bvalid && !axil_bready |=> axil_bvalid);

endmodule

/* design/spmv_pkg.sv */
// Widths, types, register map and kernel count shared by the SpMV calc block.
// Compile this package first; every design file imports it.
package spmv_pkg;

    localparam int NUM_KERNEL = 4;
    localparam int KERNEL_W   = 2;              // bits to index a kernel
    localparam int XI_DEPTH   = 256;            // entries per Xi bank
    localparam int XI_IDX_W   = 8;

    typedef logic [47:0]         hbm_addr_t;
    typedef logic [63:0]         val_word_t;   // {col, value}
    typedef logic [31:0]         reg_word_t;
    typedef logic [31:0]         axil_addr_t;
    typedef logic [1:0]          axi_resp_t;
    typedef logic [KERNEL_W-1:0] kernel_idx_t;
    typedef logic [XI_IDX_W-1:0] xi_idx_t;

    // Val regions in HBM, one region per kernel
    localparam hbm_addr_t VAL_BASE_ADDR = 48'h0000_0600_0000;
    localparam hbm_addr_t KERNEL_REGION = 48'h0000_1000_0000;
    localparam hbm_addr_t XI_ADDR_MASK  = 48'h0000_3FFF_FFFF;  // low 30 bits

    // AXI-lite map: kernel i, word j at byte 12*i + 4*j
    localparam int REG_WORDS         = 3;
    localparam int CTRL_START_BIT    = 0;
    localparam int CTRL_SOFT_RST_BIT = 7;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        reg_word_t ctrl;                      // bit 0 start, bit 7 soft reset
        reg_word_t nnz;
    } kernel_cfg_t;

    typedef struct packed {
        logic      busy;
        logic      done;
        reg_word_t result;
        reg_word_t count;                     // beats consumed so far
    } kernel_status_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_BEAT,
        MAC,
        DONE
    } engine_state_t;

endpackage
